/* Bender.yml */
package:
  name: mips_core

sources:
  - common/cpuPkg.sv
  - fetch/fetchStage.sv
  - decode/regFile.sv
  - decode/decodeStage.sv
  - execute/executeStage.sv
  - source/memStage.sv
  - source/hazardUnit.sv
  - source/mipsCore.sv
  - target: test
    files:
      - test/pipeline_chk.sv
      - test/coreMonitor.sv
      - test/coreTb.sv

/* common/cpuPkg.sv */
package cpuPkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDIU = 6'h09,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_SLT  = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_LUI
	} aluOp_e;

	typedef enum logic [1:0] {
		FWD_NONE = 2'd0,
		FWD_MEM  = 2'd1,
		FWD_WB   = 2'd2
	} fwdSel_e;

	typedef struct packed {
		opcode_e               opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] rd;
		logic [4:0]            shamt;
		funct_e                funct;
	} rFmt_t;

	typedef struct packed {
		opcode_e               opcode;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [15:0]           imm16;
	} iFmt_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [25:0] target26;
	} jFmt_t;

	// one instruction word, three views
	typedef union packed {
		rFmt_t r;
		iFmt_t i;
		jFmt_t j;
	} instr_u;

	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc;
		instr_u          instr;
	} fdReg_t;

	typedef struct packed {
		logic                  valid;
		logic                  regWrite;
		logic                  memRead;
		logic                  memWrite;
		aluOp_e                aluOp;
		logic                  useImm;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [REG_ADDR_W-1:0] destReg;
		logic [XLEN-1:0]       rsVal;
		logic [XLEN-1:0]       rtVal;
		logic [XLEN-1:0]       immExt;
		logic [XLEN-1:0]       pc;
	} deReg_t;

	typedef struct packed {
		logic                  valid;
		logic                  regWrite;
		logic                  memRead;
		logic                  memWrite;
		logic [REG_ADDR_W-1:0] destReg;
		logic [XLEN-1:0]       aluResult;
		logic [XLEN-1:0]       storeData;
		logic [XLEN-1:0]       pc;
	} emReg_t;

	typedef struct packed {
		logic                  valid;
		logic                  regWrite;
		logic [REG_ADDR_W-1:0] destReg;
		logic [XLEN-1:0]       result;
		logic [XLEN-1:0]       pc;
	} mwReg_t;

	// operand pick shared by the branch compare and the ALU inputs
	function automatic logic [XLEN-1:0] fwdMux(
		input fwdSel_e         sel,
		input logic [XLEN-1:0] regVal,
		input logic [XLEN-1:0] memVal,
		input logic [XLEN-1:0] wbVal
	);
		case (sel)
			FWD_MEM: return memVal;
			FWD_WB:  return wbVal;
			default: return regVal;
		endcase
	endfunction

endpackage

/* decode/decodeStage.sv */
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
	input  logic                  aclk,
	input  logic                  reset_i,
	input  fdReg_t                fd_i,
	input  logic                  stall_i,
	input  logic                  flush_i,
	input  fwdSel_e               fwdBrA_i,
	input  fwdSel_e               fwdBrB_i,
	input  logic [XLEN-1:0]       memResult_i,
	input  mwReg_t                wb_i,
	output logic                  redirect_o,
	output logic [XLEN-1:0]       target_o,
	output logic [REG_ADDR_W-1:0] rs_o,
	output logic [REG_ADDR_W-1:0] rt_o,
	output logic                  isBranch_o,
	output deReg_t                de_o
);

	instr_u                ins;
	logic [XLEN-1:0]       pcPlus4;
	logic [XLEN-1:0]       immSign;
	logic [XLEN-1:0]       rdataA;
	logic [XLEN-1:0]       rdataB;
	logic [XLEN-1:0]       brA;
	logic [XLEN-1:0]       brB;
	logic                  writesReg;
	logic                  usesRs;
	logic                  usesRt;
	logic                  zeroExt;
	logic                  useImm;
	logic                  memRead;
	logic                  memWrite;
	logic                  isBeq;
	logic                  isBne;
	logic                  isJump;
	logic                  taken;
	aluOp_e                aluOp;
	logic [REG_ADDR_W-1:0] destReg;
	deReg_t                deNext;

	assign ins = fd_i.instr;
	assign pcPlus4 = fd_i.pc + 32'd4;
	assign immSign = {{16{ins.i.imm16[15]}}, ins.i.imm16};

	always_comb begin
		writesReg = 1'b0;
		usesRs = 1'b1;
		usesRt = 1'b0;
		zeroExt = 1'b0;
		useImm = 1'b1;
		memRead = 1'b0;
		memWrite = 1'b0;
		isBeq = 1'b0;
		isBne = 1'b0;
		isJump = 1'b0;
		aluOp = ALU_ADD;
		destReg = ins.i.rt;
		case (ins.r.opcode)
			OP_RTYPE: begin
				usesRt = 1'b1;
				useImm = 1'b0;
				destReg = ins.r.rd;
				writesReg = 1'b1;
				case (ins.r.funct)
					FN_ADDU: aluOp = ALU_ADD;
					FN_SUBU: aluOp = ALU_SUB;
					FN_AND:  aluOp = ALU_AND;
					FN_OR:   aluOp = ALU_OR;
					FN_XOR:  aluOp = ALU_XOR;
					FN_SLT:  aluOp = ALU_SLT;
					default: writesReg = 1'b0;
				endcase
			end
			OP_ADDIU: writesReg = 1'b1;
			OP_ORI: begin
				writesReg = 1'b1;
				zeroExt = 1'b1;
				aluOp = ALU_OR;
			end
			OP_LUI: begin
				writesReg = 1'b1;
				usesRs = 1'b0;
				zeroExt = 1'b1;
				aluOp = ALU_LUI;
			end
			OP_LW: begin
				writesReg = 1'b1;
				memRead = 1'b1;
			end
			OP_SW: begin
				usesRt = 1'b1;
				memWrite = 1'b1;
			end
			OP_BEQ: begin
				usesRt = 1'b1;
				isBeq = 1'b1;
			end
			OP_BNE: begin
				usesRt = 1'b1;
				isBne = 1'b1;
			end
			OP_J: begin
				usesRs = 1'b0;
				isJump = 1'b1;
			end
			default: usesRs = 1'b0;
		endcase
	end

	// unread sources show as $0 so they never raise a hazard
	assign rs_o = (fd_i.valid && usesRs) ? ins.r.rs : '0;
	assign rt_o = (fd_i.valid && usesRt) ? ins.r.rt : '0;
	assign isBranch_o = fd_i.valid & (isBeq | isBne);

	regFile u_regFile (
		.aclk     (aclk),
		.raddrA_i (rs_o),
		.raddrB_i (rt_o),
		.rdataA_o (rdataA),
		.rdataB_o (rdataB),
		.wb_i     (wb_i)
	);

	assign brA = fwdMux(fwdBrA_i, rdataA, memResult_i, wb_i.result);
	assign brB = fwdMux(fwdBrB_i, rdataB, memResult_i, wb_i.result);

	assign taken = (isBeq & (brA == brB)) | (isBne & (brA != brB)) | isJump;
	assign redirect_o = fd_i.valid & ~stall_i & taken;
	assign target_o = isJump ? {pcPlus4[31:28], ins.j.target26, 2'b00}
		: pcPlus4 + {immSign[XLEN-3:0], 2'b00};

	always_comb begin
		deNext.valid = fd_i.valid;
		deNext.regWrite = fd_i.valid & writesReg & (destReg != '0);
		deNext.memRead = fd_i.valid & memRead;
		deNext.memWrite = fd_i.valid & memWrite;
		deNext.aluOp = aluOp;
		deNext.useImm = useImm;
		deNext.rs = rs_o;
		deNext.rt = rt_o;
		deNext.destReg = destReg;
		deNext.rsVal = rdataA;
		deNext.rtVal = rdataB;
		deNext.immExt = zeroExt ? {16'h0, ins.i.imm16} : immSign;
		deNext.pc = fd_i.pc;
	end

	always_ff @(posedge aclk) begin
		if (reset_i || flush_i) begin
			de_o.valid <= 1'b0;
			de_o.regWrite <= 1'b0;
			de_o.memRead <= 1'b0;
			de_o.memWrite <= 1'b0;
		end else begin
			de_o <= deNext;
		end
	end

endmodule

/* decode/regFile.sv */
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
	input  logic                  aclk,
	input  logic [REG_ADDR_W-1:0] raddrA_i,
	input  logic [REG_ADDR_W-1:0] raddrB_i,
	output logic [XLEN-1:0]       rdataA_o,
	output logic [XLEN-1:0]       rdataB_o,
	input  mwReg_t                wb_i
);

	// $0 has no storage
	logic [XLEN-1:0] regs [1:2**REG_ADDR_W-1];
	logic            wbWrite;

	assign wbWrite = wb_i.valid && wb_i.regWrite && (wb_i.destReg != '0);

	always_ff @(posedge aclk) begin
		if (wbWrite)
			regs[wb_i.destReg] <= wb_i.result;
	end

	function automatic logic [XLEN-1:0] readPort(input logic [REG_ADDR_W-1:0] addr);
		if (addr == '0)
			return '0;
		else if (wbWrite && (addr == wb_i.destReg))
			return wb_i.result;
		else
			return regs[addr];
	endfunction

	always_comb begin
		rdataA_o = readPort(raddrA_i);
		rdataB_o = readPort(raddrB_i);
	end

endmodule

/* execute/executeStage.sv */
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
	input  logic            aclk,
	input  logic            reset_i,
	input  deReg_t          de_i,
	input  fwdSel_e         fwdA_i,
	input  fwdSel_e         fwdB_i,
	input  logic [XLEN-1:0] memResult_i,
	input  logic [XLEN-1:0] wbResult_i,
	output emReg_t          em_o
);

	logic [XLEN-1:0] opA;
	logic [XLEN-1:0] opB;
	logic [XLEN-1:0] srcB;
	logic [XLEN-1:0] aluResult;

	assign opA = fwdMux(fwdA_i, de_i.rsVal, memResult_i, wbResult_i);
	assign opB = fwdMux(fwdB_i, de_i.rtVal, memResult_i, wbResult_i);
	assign srcB = de_i.useImm ? de_i.immExt : opB;

	always_comb begin
		case (de_i.aluOp)
			ALU_SUB: aluResult = opA - srcB;
			ALU_AND: aluResult = opA & srcB;
			ALU_OR:  aluResult = opA | srcB;
			ALU_XOR: aluResult = opA ^ srcB;
			ALU_SLT: aluResult = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(srcB)};
			// immediate goes to the upper half
			ALU_LUI: aluResult = {srcB[15:0], 16'h0};
			default: aluResult = opA + srcB;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (reset_i) begin
			em_o.valid <= 1'b0;
			em_o.regWrite <= 1'b0;
			em_o.memRead <= 1'b0;
			em_o.memWrite <= 1'b0;
		end else begin
			em_o.valid <= de_i.valid;
			em_o.regWrite <= de_i.regWrite;
			em_o.memRead <= de_i.memRead;
			em_o.memWrite <= de_i.memWrite;
			em_o.destReg <= de_i.destReg;
			em_o.aluResult <= aluResult;
			// store data is the forwarded rt
			em_o.storeData <= opB;
			em_o.pc <= de_i.pc;
		end
	end

endmodule

/* fetch/fetchStage.sv */
`timescale 1ns/1ps

module fetchStage import cpuPkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000
) (
	input  logic            aclk,
	input  logic            reset_i,
	input  logic            stall_i,
	input  logic            redirect_i,
	input  logic [XLEN-1:0] target_i,
	output logic [XLEN-1:0] instAddr_o,
	input  instr_u          instData_i,
	output fdReg_t          fd_o
);

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pcNext;

	assign instAddr_o = pc;

	// redirect lands after the delay slot, which is being fetched now
	assign pcNext = redirect_i ? target_i : pc + 32'd4;

	always_ff @(posedge aclk) begin
		if (reset_i) begin
			pc <= RESET_PC;
		end else if (!stall_i) begin
			pc <= pcNext;
		end
	end

	always_ff @(posedge aclk) begin
		if (reset_i) begin
			fd_o.valid <= 1'b0;
		end else if (!stall_i) begin
			fd_o.valid <= 1'b1;
			fd_o.pc <= pc;
			fd_o.instr <= instData_i;
		end
	end

endmodule

/* sim.f */
common/cpuPkg.sv
fetch/fetchStage.sv
decode/regFile.sv
decode/decodeStage.sv
execute/executeStage.sv
source/memStage.sv
source/hazardUnit.sv
source/mipsCore.sv
test/pipeline_chk.sv
test/coreMonitor.sv
test/coreTb.sv

/* source/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import cpuPkg::*; (
	input  logic [REG_ADDR_W-1:0] rsD_i,
	input  logic [REG_ADDR_W-1:0] rtD_i,
	input  logic                  isBranchD_i,
	input  deReg_t                de_i,
	input  emReg_t                em_i,
	input  mwReg_t                mw_i,
	output logic                  stallF_o,
	output logic                  stallD_o,
	output logic                  flushE_o,
	output fwdSel_e               fwdA_o,
	output fwdSel_e               fwdB_o,
	output fwdSel_e               fwdBrA_o,
	output fwdSel_e               fwdBrB_o
);

	logic hitE;
	logic hitM;
	logic loadUse;
	logic branchOnExec;
	logic branchOnLoad;
	logic stall;

	function automatic logic srcHit(
		input logic [REG_ADDR_W-1:0] src,
		input logic [REG_ADDR_W-1:0] dest
	);
		return (src != '0) && (src == dest);
	endfunction

	// memory stage is younger, so it wins over writeback
	function automatic fwdSel_e pickFwd(
		input logic [REG_ADDR_W-1:0] src,
		input emReg_t                em,
		input mwReg_t                mw
	);
		if (em.valid && em.regWrite && srcHit(src, em.destReg))
			return FWD_MEM;
		else if (mw.valid && mw.regWrite && srcHit(src, mw.destReg))
			return FWD_WB;
		else
			return FWD_NONE;
	endfunction

	assign hitE = srcHit(rsD_i, de_i.destReg) || srcHit(rtD_i, de_i.destReg);
	assign hitM = srcHit(rsD_i, em_i.destReg) || srcHit(rtD_i, em_i.destReg);

	assign loadUse = de_i.valid && de_i.memRead && hitE;
	assign branchOnExec = isBranchD_i && de_i.valid && de_i.regWrite && hitE;
	// load data is too late for the decode compare
	assign branchOnLoad = isBranchD_i && em_i.valid && em_i.memRead && em_i.regWrite && hitM;

	assign stall = loadUse || branchOnExec || branchOnLoad;
	assign stallF_o = stall;
	assign stallD_o = stall;
	assign flushE_o = stall;

	assign fwdA_o = pickFwd(de_i.rs, em_i, mw_i);
	assign fwdB_o = pickFwd(de_i.rt, em_i, mw_i);
	assign fwdBrA_o = pickFwd(rsD_i, em_i, mw_i);
	assign fwdBrB_o = pickFwd(rtD_i, em_i, mw_i);

endmodule

/* source/memStage.sv */
`timescale 1ns/1ps

module memStage import cpuPkg::*; (
	input  logic            aclk,
	input  logic            reset_i,
	input  emReg_t          em_i,
	output logic            dataReq_o,
	output logic            dataWe_o,
	output logic [XLEN-1:0] dataAddr_o,
	output logic [XLEN-1:0] dataWdata_o,
	input  logic [XLEN-1:0] dataRdata_i,
	output logic [XLEN-1:0] memResult_o,
	output mwReg_t          mw_o
);

	// one strobe per valid load or store
	assign dataReq_o = em_i.valid & (em_i.memRead | em_i.memWrite);
	assign dataWe_o = em_i.valid & em_i.memWrite;
	assign dataAddr_o = em_i.aluResult;
	assign dataWdata_o = em_i.storeData;

	// read data comes back in the same cycle
	assign memResult_o = em_i.memRead ? dataRdata_i : em_i.aluResult;

	always_ff @(posedge aclk) begin
		if (reset_i) begin
			mw_o.valid <= 1'b0;
			mw_o.regWrite <= 1'b0;
		end else begin
			mw_o.valid <= em_i.valid;
			mw_o.regWrite <= em_i.regWrite;
			mw_o.destReg <= em_i.destReg;
			mw_o.result <= memResult_o;
			mw_o.pc <= em_i.pc;
		end
	end

endmodule

/* source/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import cpuPkg::*; #(
	parameter logic [XLEN-1:0] RESET_PC = 32'h0000_0000
) (
	input  logic                  aclk,
	input  logic                  reset_i,
	output logic [XLEN-1:0]       instAddr_o,
	input  logic [XLEN-1:0]       instData_i,
	output logic                  dataReq_o,
	output logic                  dataWe_o,
	output logic [XLEN-1:0]       dataAddr_o,
	output logic [XLEN-1:0]       dataWdata_o,
	input  logic [XLEN-1:0]       dataRdata_i,
	output logic [XLEN-1:0]       wbPc_o,
	output logic                  wbWe_o,
	output logic [REG_ADDR_W-1:0] wbNum_o,
	output logic [XLEN-1:0]       wbData_o
);

	fdReg_t                fd;
	deReg_t                de;
	emReg_t                em;
	mwReg_t                mw;
	logic                  stallF;
	logic                  stallD;
	logic                  flushE;
	fwdSel_e               fwdA;
	fwdSel_e               fwdB;
	fwdSel_e               fwdBrA;
	fwdSel_e               fwdBrB;
	logic                  redirect;
	logic [XLEN-1:0]       target;
	logic [REG_ADDR_W-1:0] rsD;
	logic [REG_ADDR_W-1:0] rtD;
	logic                  isBranchD;
	logic [XLEN-1:0]       memResult;

	// regWrite already excludes bubbles and $0
	assign wbPc_o = mw.pc;
	assign wbWe_o = mw.regWrite;
	assign wbNum_o = mw.destReg;
	assign wbData_o = mw.result;

	fetchStage #(
		.RESET_PC (RESET_PC)
	) u_fetchStage (
		.aclk       (aclk),
		.reset_i    (reset_i),
		.stall_i    (stallF),
		.redirect_i (redirect),
		.target_i   (target),
		.instAddr_o (instAddr_o),
		.instData_i (instData_i),
		.fd_o       (fd)
	);

	decodeStage u_decodeStage (
		.aclk        (aclk),
		.reset_i     (reset_i),
		.fd_i        (fd),
		.stall_i     (stallD),
		.flush_i     (flushE),
		.fwdBrA_i    (fwdBrA),
		.fwdBrB_i    (fwdBrB),
		.memResult_i (memResult),
		.wb_i        (mw),
		.redirect_o  (redirect),
		.target_o    (target),
		.rs_o        (rsD),
		.rt_o        (rtD),
		.isBranch_o  (isBranchD),
		.de_o        (de)
	);

	executeStage u_executeStage (
		.aclk        (aclk),
		.reset_i     (reset_i),
		.de_i        (de),
		.fwdA_i      (fwdA),
		.fwdB_i      (fwdB),
		.memResult_i (memResult),
		.wbResult_i  (mw.result),
		.em_o        (em)
	);

	memStage u_memStage (
		.aclk        (aclk),
		.reset_i     (reset_i),
		.em_i        (em),
		.dataReq_o   (dataReq_o),
		.dataWe_o    (dataWe_o),
		.dataAddr_o  (dataAddr_o),
		.dataWdata_o (dataWdata_o),
		.dataRdata_i (dataRdata_i),
		.memResult_o (memResult),
		.mw_o        (mw)
	);

	hazardUnit u_hazardUnit (
		.rsD_i       (rsD),
		.rtD_i       (rtD),
		.isBranchD_i (isBranchD),
		.de_i        (de),
		.em_i        (em),
		.mw_i        (mw),
		.stallF_o    (stallF),
		.stallD_o    (stallD),
		.flushE_o    (flushE),
		.fwdA_o      (fwdA),
		.fwdB_o      (fwdB),
		.fwdBrA_o    (fwdBrA),
		.fwdBrB_o    (fwdBrB)
	);

endmodule

/* test/coreMonitor.sv */
`timescale 1ns/1ps

module coreMonitor #(
	parameter int MAX_EXP = 64
) (
	input  logic        aclk,
	input  logic        reset_i,
	input  logic [31:0] wbPc_i,
	input  logic        wbWe_i,
	input  logic [4:0]  wbNum_i,
	input  logic [31:0] wbData_i,
	output int          errCount_o,
	output int          pending_o
);

	string       expName [MAX_EXP];
	logic [31:0] expPc [MAX_EXP];
	logic [4:0]  expNum [MAX_EXP];
	logic [31:0] expData [MAX_EXP];
	int          expCount = 0;
	int          nextIdx = 0;
	int          errors = 0;

	assign errCount_o = errors;
	assign pending_o = expCount - nextIdx;

	// expectations arrive in program order
	task automatic expectWrite(input string name, input logic [31:0] pc, input logic [4:0] num,
		input logic [31:0] data);
		expName[expCount] = name;
		expPc[expCount] = pc;
		expNum[expCount] = num;
		expData[expCount] = data;
		expCount++;
	endtask

	// debug port is steady at the falling edge
	always @(negedge aclk) begin
		if (!reset_i) begin
			if (wbWe_i !== 1'b0 && wbWe_i !== 1'b1) begin
				$display("debug write enable is unknown at time %0t", $time);
				errors++;
			end else if (wbWe_i && nextIdx >= expCount) begin
				$display("unexpected register write of $%0d = %08h from pc %08h",
					wbNum_i, wbData_i, wbPc_i);
				errors++;
			end else if (wbWe_i) begin
				if (wbPc_i !== expPc[nextIdx] || wbNum_i !== expNum[nextIdx]
					|| wbData_i !== expData[nextIdx]) begin
					$display("Error: %s expected $%0d=%08h pc %08h, actual $%0d=%08h pc %08h",
						expName[nextIdx], expNum[nextIdx], expData[nextIdx], expPc[nextIdx],
						wbNum_i, wbData_i, wbPc_i);
					errors++;
				end
				nextIdx++;
			end
		end
	end

endmodule

/* test/coreTb.sv */
`timescale 1ns/1ps

module coreTb;

	localparam int PROG_LEN = 32;
	localparam int CYCLE_LIMIT = 4 * PROG_LEN + 50;
	localparam int DMEM_WORDS = 64;
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	// MIPS major opcodes and R-type function codes
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LUI = 6'h0f;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2a;

	logic        aclk = 1'b0;
	logic        reset;
	logic [31:0] instAddr;
	logic [31:0] instData;
	logic        dataReq;
	logic        dataWe;
	logic [31:0] dataAddr;
	logic [31:0] dataWdata;
	logic [31:0] dataRdata;
	logic [31:0] wbPc;
	logic        wbWe;
	logic [4:0]  wbNum;
	logic [31:0] wbData;
	int          errCount;
	int          pending;
	int          assertFails;
	int          cycles;
	int          progFill = 0;

	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] progWord [PROG_LEN];
	string       progName [PROG_LEN];
	logic        progHasWb [PROG_LEN];
	logic [4:0]  progReg [PROG_LEN];
	logic [31:0] progVal [PROG_LEN];

	always #10 aclk = ~aclk;

	mipsCore #(
		.RESET_PC (RESET_PC)
	) u_mipsCore (
		.aclk        (aclk),
		.reset_i     (reset),
		.instAddr_o  (instAddr),
		.instData_i  (instData),
		.dataReq_o   (dataReq),
		.dataWe_o    (dataWe),
		.dataAddr_o  (dataAddr),
		.dataWdata_o (dataWdata),
		.dataRdata_i (dataRdata),
		.wbPc_o      (wbPc),
		.wbWe_o      (wbWe),
		.wbNum_o     (wbNum),
		.wbData_o    (wbData)
	);

	coreMonitor u_coreMonitor (
		.aclk       (aclk),
		.reset_i    (reset),
		.wbPc_i     (wbPc),
		.wbWe_i     (wbWe),
		.wbNum_i    (wbNum),
		.wbData_i   (wbData),
		.errCount_o (errCount),
		.pending_o  (pending)
	);

	function automatic logic [31:0] rWord(input logic [5:0] funct, input int rd, input int rs,
		input int rt);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'h00, funct};
	endfunction

	function automatic logic [31:0] iWord(input logic [5:0] op, input int rt, input int rs,
		input logic [15:0] imm);
		return {op, rs[4:0], rt[4:0], imm};
	endfunction

	function automatic logic [31:0] jWord(input int wordIdx);
		return {OP_J, wordIdx[25:0]};
	endfunction

	// past the program end the core sees NOPs
	function automatic logic [31:0] fetchWord(input logic [31:0] addr);
		logic [31:0] idx;
		idx = (addr - RESET_PC) >> 2;
		if (idx < PROG_LEN)
			return progWord[idx];
		else
			return 32'h0000_0000;
	endfunction

	task automatic addEntry(input logic [31:0] word, input string name, input logic hasWb,
		input int num, input logic [31:0] value);
		progWord[progFill] = word;
		progName[progFill] = name;
		progHasWb[progFill] = hasWb;
		progReg[progFill] = num[4:0];
		progVal[progFill] = value;
		progFill++;
	endtask

	task automatic loadProgram();
		addEntry(iWord(OP_ADDIU, 1, 0, 16'd5), "addiu_pos", 1'b1, 1, 32'h0000_0005);
		addEntry(iWord(OP_ADDIU, 2, 0, 16'hfffd), "addiu_neg", 1'b1, 2, 32'hffff_fffd);
		addEntry(rWord(FN_ADDU, 3, 1, 2), "addu_fwd", 1'b1, 3, 32'h0000_0002);
		addEntry(rWord(FN_SUBU, 4, 3, 1), "subu_fwd", 1'b1, 4, 32'hffff_fffd);
		addEntry(iWord(OP_ORI, 5, 0, 16'hf0f7), "ori_zext", 1'b1, 5, 32'h0000_f0f7);
		addEntry(iWord(OP_LUI, 6, 0, 16'h1234), "lui", 1'b1, 6, 32'h1234_0000);
		addEntry(rWord(FN_OR, 7, 6, 5), "or", 1'b1, 7, 32'h1234_f0f7);
		addEntry(rWord(FN_AND, 8, 7, 2), "and", 1'b1, 8, 32'h1234_f0f5);
		addEntry(rWord(FN_XOR, 9, 7, 6), "xor", 1'b1, 9, 32'h0000_f0f7);
		addEntry(rWord(FN_SLT, 10, 2, 1), "slt_true", 1'b1, 10, 32'h0000_0001);
		addEntry(rWord(FN_SLT, 11, 1, 2), "slt_false", 1'b1, 11, 32'h0000_0000);
		addEntry(iWord(OP_ADDIU, 0, 1, 16'd7), "write_r0", 1'b0, 0, 32'h0);
		addEntry(rWord(FN_ADDU, 12, 0, 1), "read_r0", 1'b1, 12, 32'h0000_0005);
		addEntry(iWord(OP_ORI, 13, 0, 16'h0040), "base_addr", 1'b1, 13, 32'h0000_0040);
		addEntry(iWord(OP_SW, 7, 13, 16'd4), "sw", 1'b0, 0, 32'h0);
		addEntry(iWord(OP_LW, 14, 13, 16'd4), "lw", 1'b1, 14, 32'h1234_f0f7);
		addEntry(rWord(FN_ADDU, 15, 14, 1), "load_use", 1'b1, 15, 32'h1234_f0fc);
		addEntry(iWord(OP_ADDIU, 16, 0, 16'd3), "branch_src", 1'b1, 16, 32'h0000_0003);
		addEntry(iWord(OP_BNE, 0, 16, 16'd2), "bne_taken", 1'b0, 0, 32'h0);
		addEntry(iWord(OP_ADDIU, 17, 0, 16'd1), "bne_slot", 1'b1, 17, 32'h0000_0001);
		addEntry(iWord(OP_ADDIU, 18, 0, 16'h07ff), "bne_skip", 1'b0, 0, 32'h0);
		addEntry(iWord(OP_ADDIU, 19, 16, 16'd4), "bne_target", 1'b1, 19, 32'h0000_0007);
		addEntry(iWord(OP_BEQ, 16, 19, 16'd3), "beq_not_taken", 1'b0, 0, 32'h0);
		addEntry(iWord(OP_ADDIU, 20, 0, 16'd9), "beq_fall", 1'b1, 20, 32'h0000_0009);
		addEntry(jWord(27), "jump", 1'b0, 0, 32'h0);
		addEntry(rWord(FN_ADDU, 21, 20, 19), "jump_slot", 1'b1, 21, 32'h0000_0010);
		addEntry(iWord(OP_ADDIU, 22, 0, 16'h0055), "jump_skip", 1'b0, 0, 32'h0);
		addEntry(iWord(OP_LW, 23, 0, 16'h0044), "lw_again", 1'b1, 23, 32'h1234_f0f7);
		addEntry(iWord(OP_BEQ, 7, 23, 16'd2), "beq_on_load", 1'b0, 0, 32'h0);
		addEntry(rWord(FN_SUBU, 24, 23, 7), "beq_slot", 1'b1, 24, 32'h0000_0000);
		addEntry(iWord(OP_ADDIU, 25, 0, 16'd1), "beq_skip", 1'b0, 0, 32'h0);
		addEntry(iWord(OP_ADDIU, 26, 24, 16'h0100), "beq_target", 1'b1, 26, 32'h0000_0100);
	endtask

	// memories answer within the cycle, driven just after the edge
	always @(posedge aclk) begin
		if (dataReq === 1'b1 && dataWe === 1'b1)
			dmem[dataAddr[7:2]] = dataWdata;
		#2;
		instData = fetchWord(instAddr);
		dataRdata = dmem[dataAddr[7:2]];
	end

	initial begin
		reset = 1'b1;
		instData = '0;
		dataRdata = '0;
		for (int i = 0; i < DMEM_WORDS; i++)
			dmem[i] = 32'ha5a5_a5a5 ^ (i << 2);
		loadProgram();
		for (int i = 0; i < PROG_LEN; i++) begin
			if (progHasWb[i])
				u_coreMonitor.expectWrite(progName[i], RESET_PC + 4 * i, progReg[i],
					progVal[i]);
		end
		repeat (8) @(posedge aclk);
		#2 reset = 1'b0;
		cycles = 0;
		while (pending != 0 && cycles < CYCLE_LIMIT) begin
			@(posedge aclk);
			cycles++;
		end
		if (pending != 0)
			$display("timeout after %0d cycles, %0d expected writebacks never arrived",
				cycles, pending);
		// skipped slots would retire within a few cycles
		repeat (10) @(posedge aclk);
		assertFails = u_mipsCore.u_pipelineChk.failures;
		$display("%0d writeback errors, %0d assertion failures, %0d missing writebacks",
			errCount, assertFails, pending);
		if (errCount == 0 && assertFails == 0 && pending == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* test/pipeline_chk.sv */
`timescale 1ns/1ps

module pipeline_chk (
	input logic aclk,
	input logic reset_i,
	input logic stallD_i,
	input logic flushE_i,
	input logic dataReq_i,
	input logic memValid_i
);

	int failures = 0;

	// a bubble into execute only while decode holds
	flushNeedsStall: assert property (@(posedge aclk) disable iff (reset_i)
		flushE_i |-> stallD_i)
		else begin
			failures++;
			$error("flush into execute without a decode stall");
		end

	reqNeedsValid: assert property (@(posedge aclk) disable iff (reset_i)
		$rose(dataReq_i) |-> memValid_i)
		else begin
			failures++;
			$error("data request rose with an invalid memory stage");
		end

endmodule

bind mipsCore pipeline_chk u_pipelineChk (
	.aclk       (aclk),
	.reset_i    (reset_i),
	.stallD_i   (stallD),
	.flushE_i   (flushE),
	.dataReq_i  (dataReq_o),
	.memValid_i (em.valid)
);
